// File: source/capitol_ctrl_pkg.sv
/* Capitol control package
   Key codes, keyboard events, panel buttons and game control types */
package capitol_ctrl_pkg;

	// PS/2 set-2 scan code
	typedef logic [7:0] key_code_t;

	// Joystick byte, low six bits used
	typedef logic [7:0] joy_t;

	//----------------------------------------------------------------------
	// Key codes recognised by the panel latch
	//----------------------------------------------------------------------
	localparam key_code_t KEY_UP      = 8'h75; // Cursor up
	localparam key_code_t KEY_DOWN    = 8'h72; // Cursor down
	localparam key_code_t KEY_LEFT    = 8'h6B; // Cursor left
	localparam key_code_t KEY_RIGHT   = 8'h74; // Cursor right
	localparam key_code_t KEY_COIN    = 8'h76; // ESC
	localparam key_code_t KEY_START1  = 8'h05; // F1
	localparam key_code_t KEY_START2  = 8'h06; // F2
	localparam key_code_t KEY_FIRE    = 8'h29; // Space
	localparam key_code_t KEY_BARRIER = 8'h11; // Alt

	// Joystick bit positions
	localparam int unsigned JOY_RIGHT   = 0;
	localparam int unsigned JOY_LEFT    = 1;
	localparam int unsigned JOY_DOWN    = 2;
	localparam int unsigned JOY_UP      = 3;
	localparam int unsigned JOY_FIRE    = 4;
	localparam int unsigned JOY_BARRIER = 5;

	// Single-cycle key event from the host
	typedef struct packed {
		logic      strobe;
		logic      pressed;
		key_code_t code;
	} key_event_t;

	// Latched keyboard buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic barrier;
	} panel_t;

	// Control inputs of the game core
	typedef struct packed {
		logic       coin;
		logic [1:0] start; // Two-player, one-player
		logic       left;
		logic       right;
		logic       barrier;
		logic       fire;
	} game_ctrl_t;

endpackage

// File: source/capitol_av_pkg.sv
/* Capitol video and audio package
   Colour channel types, scanline levels and audio modulator widths */
package capitol_av_pkg;

	//----------------------------------------------------------------------
	// Video
	//----------------------------------------------------------------------
	typedef logic [1:0] color2_t; // Game colour channel
	typedef logic [5:0] color6_t; // Monitor colour channel

	typedef struct packed {
		color2_t r;
		color2_t g;
		color2_t b;
	} rgb2_t;

	typedef struct packed {
		color6_t r;
		color6_t g;
		color6_t b;
	} rgb6_t;

	// Dimming of odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scan_level_t;

	//----------------------------------------------------------------------
	// Audio
	//----------------------------------------------------------------------
	localparam int unsigned AUDIO_BITS = 12;
	localparam int unsigned DAC_BITS   = 15; // Modulator input width

	typedef logic [AUDIO_BITS-1:0] audio_t; // Unsigned sample
	typedef logic [DAC_BITS:0]     dac_acc_t; // Accumulator plus carry

endpackage

// File: source/key_latch.sv
/* Keyboard panel latch
   Keeps one button state per known key from strobed press and release events */
`timescale 1ns/1ps

module key_latch (
	input  logic                        clk_22,
	input  logic                        rst_n,
	input  capitol_ctrl_pkg::key_event_t key_ev,
	output capitol_ctrl_pkg::panel_t     panel
);

	logic hit; // Strobe carries a new state

	assign hit = key_ev.strobe;

	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			panel <= '0;
		end else if (hit) begin
			case (key_ev.code)
				capitol_ctrl_pkg::KEY_UP: begin
					panel.up <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_DOWN: begin
					panel.down <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_LEFT: begin
					panel.left <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_RIGHT: begin
					panel.right <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_COIN: begin
					panel.coin <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_START1: begin
					panel.start1 <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_START2: begin
					panel.start2 <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_FIRE: begin
					panel.fire <= key_ev.pressed;
				end
				capitol_ctrl_pkg::KEY_BARRIER: begin
					panel.barrier <= key_ev.pressed;
				end
				default: begin
					// Unknown codes leave the panel alone
				end
			endcase
		end
	end

endmodule

// File: source/control_mapper.sv
/* Control mapper
   Merges keyboard panel and two joysticks into game controls, with rotation */
`timescale 1ns/1ps

module control_mapper (
	input  logic                        clk_22,
	input  logic                        rst_n,
	input  capitol_ctrl_pkg::panel_t     panel,
	input  capitol_ctrl_pkg::joy_t       joy_0,
	input  capitol_ctrl_pkg::joy_t       joy_1,
	input  logic                        rotate,
	input  logic                        menu_reset,
	input  logic                        button_reset,
	output capitol_ctrl_pkg::game_ctrl_t game_ctrl,
	output logic                        game_reset
);

	capitol_ctrl_pkg::joy_t joy_any; // Either stick
	logic left_next;
	logic right_next;
	logic fire_next;
	logic barrier_next;

	assign joy_any = joy_0 | joy_1;

	assign fire_next    = panel.fire | joy_any[capitol_ctrl_pkg::JOY_FIRE];
	assign barrier_next = panel.barrier | joy_any[capitol_ctrl_pkg::JOY_BARRIER];

	// Unrotated cabinet uses the vertical axis for horizontal motion
	always_comb begin
		if (rotate) begin
			left_next  = panel.left | joy_any[capitol_ctrl_pkg::JOY_LEFT];
			right_next = panel.right | joy_any[capitol_ctrl_pkg::JOY_RIGHT];
		end else begin
			left_next  = panel.down | joy_any[capitol_ctrl_pkg::JOY_DOWN];
			right_next = panel.up | joy_any[capitol_ctrl_pkg::JOY_UP];
		end
	end

	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			game_ctrl  <= '0;
			game_reset <= 1'b1; // Core held in reset with the board
		end else begin
			game_ctrl.coin    <= panel.coin; // Keyboard only
			game_ctrl.start   <= {panel.start2, panel.start1};
			game_ctrl.left    <= left_next;
			game_ctrl.right   <= right_next;
			game_ctrl.barrier <= barrier_next;
			game_ctrl.fire    <= fire_next;
			game_reset        <= menu_reset | button_reset;
		end
	end

endmodule

// File: source/video_gate.sv
/* Video gate
   Blanks, widens to 6 bits and scanline-dims the game video, inverts the syncs */
`timescale 1ns/1ps

module video_gate (
	input  logic                        clk_22,
	input  logic                        rst_n,
	input  capitol_av_pkg::rgb2_t       pix,
	input  logic                        hblank_bg,
	input  logic                        hblank_fg,
	input  logic                        vblank,
	input  logic                        hsync,
	input  logic                        vsync,
	input  capitol_av_pkg::scan_level_t scan,
	output capitol_av_pkg::rgb6_t       pix_out,
	output logic                        hs_n,
	output logic                        vs_n
);

	logic blank;
	logic hsync_d;  // For the line edge
	logic odd_line; // Current line parity

	// Widen one channel and dim it on odd lines
	function automatic capitol_av_pkg::color6_t shade(
		input capitol_av_pkg::color2_t     c,
		input capitol_av_pkg::scan_level_t lvl,
		input logic                        odd
	);
		capitol_av_pkg::color6_t wide;
		capitol_av_pkg::color6_t dim;
		wide = {3{c}};
		case (lvl)
			capitol_av_pkg::SCAN_25: dim = wide - (wide >> 2);
			capitol_av_pkg::SCAN_50: dim = wide >> 1;
			capitol_av_pkg::SCAN_75: dim = wide >> 2;
			default:                 dim = wide;
		endcase
		return odd ? dim : wide;
	endfunction

	assign blank = vblank | (hblank_bg & hblank_fg);

	//----------------------------------------------------------------------
	// Line parity, reset at each frame
	//----------------------------------------------------------------------
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			hsync_d  <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hsync_d <= hsync;
			if (vsync)
				odd_line <= 1'b0; // First line of a frame is even
			else if (hsync && !hsync_d)
				odd_line <= ~odd_line;
		end
	end

	//----------------------------------------------------------------------
	// Output register
	//----------------------------------------------------------------------
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			pix_out <= '0;
			hs_n    <= 1'b1;
			vs_n    <= 1'b1;
		end else begin
			hs_n <= ~hsync;
			vs_n <= ~vsync;
			if (blank) begin
				pix_out <= '0;
			end else begin
				pix_out.r <= shade(pix.r, scan, odd_line);
				pix_out.g <= shade(pix.g, scan, odd_line);
				pix_out.b <= shade(pix.b, scan, odd_line);
			end
		end
	end

endmodule

// File: source/sigma_delta_dac.sv
/* Sigma-delta audio DAC
   First-order one-bit modulator for the 12-bit game audio */
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic                   clk_22,
	input  logic                   rst_n,
	input  capitol_av_pkg::audio_t audio,
	output logic                   audio_bit
);

	localparam int unsigned PAD_BITS = capitol_av_pkg::DAC_BITS - capitol_av_pkg::AUDIO_BITS;

	capitol_av_pkg::dac_acc_t acc;
	capitol_av_pkg::dac_acc_t sample; // Audio scaled to the modulator width
	capitol_av_pkg::dac_acc_t residue; // Accumulator without its carry

	// Sample with zero low bits and a clear carry position
	assign sample = {1'b0, audio, {PAD_BITS{1'b0}}};

	assign residue = {1'b0, acc[capitol_av_pkg::DAC_BITS-1:0]};

	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= residue + sample;
		end
	end

	// Carry out of the last add is the bit stream
	assign audio_bit = acc[capitol_av_pkg::DAC_BITS];

endmodule

// File: source/capitol_io_top.sv
/* Capitol I/O shell
   Player controls, monitor video and audio bit stream around the game core */
`timescale 1ns/1ps

module capitol_io_top (
	input  logic                        clk_22,
	input  logic                        rst_n,

	// Player inputs
	input  capitol_ctrl_pkg::key_event_t key_ev,
	input  capitol_ctrl_pkg::joy_t       joy_0,
	input  capitol_ctrl_pkg::joy_t       joy_1,

	// Menu options
	input  logic                        rotate,
	input  logic                        menu_reset,
	input  logic                        button_reset,
	input  capitol_av_pkg::scan_level_t scan,

	// Game video
	input  capitol_av_pkg::rgb2_t       pix,
	input  logic                        hblank_bg,
	input  logic                        hblank_fg,
	input  logic                        vblank,
	input  logic                        hsync,
	input  logic                        vsync,

	// Game audio
	input  capitol_av_pkg::audio_t      audio,

	// Outputs
	output capitol_ctrl_pkg::game_ctrl_t game_ctrl,
	output logic                        game_reset,
	output capitol_av_pkg::rgb6_t       pix_out,
	output logic                        hs_n,
	output logic                        vs_n,
	output logic                        audio_l,
	output logic                        audio_r
);

	capitol_ctrl_pkg::panel_t panel;
	logic                     audio_bit;

	//----------------------------------------------------------------------
	// Controls
	//----------------------------------------------------------------------
	key_latch key_latch_inst (
		.clk_22 (clk_22),
		.rst_n  (rst_n),
		.key_ev (key_ev),
		.panel  (panel)
	);

	control_mapper control_mapper_inst (
		.clk_22       (clk_22),
		.rst_n        (rst_n),
		.panel        (panel),
		.joy_0        (joy_0),
		.joy_1        (joy_1),
		.rotate       (rotate),
		.menu_reset   (menu_reset),
		.button_reset (button_reset),
		.game_ctrl    (game_ctrl),
		.game_reset   (game_reset)
	);

	//----------------------------------------------------------------------
	// Video and audio
	//----------------------------------------------------------------------
	video_gate video_gate_inst (
		.clk_22    (clk_22),
		.rst_n     (rst_n),
		.pix       (pix),
		.hblank_bg (hblank_bg),
		.hblank_fg (hblank_fg),
		.vblank    (vblank),
		.hsync     (hsync),
		.vsync     (vsync),
		.scan      (scan),
		.pix_out   (pix_out),
		.hs_n      (hs_n),
		.vs_n      (vs_n)
	);

	sigma_delta_dac sigma_delta_dac_inst (
		.clk_22    (clk_22),
		.rst_n     (rst_n),
		.audio     (audio),
		.audio_bit (audio_bit)
	);

	assign audio_l = audio_bit; // Mono game, same stream on both sides
	assign audio_r = audio_bit;

endmodule

// File: bench/capitol_io_tb.sv
/* Capitol I/O shell testbench
   Drives controls, video and audio and checks the outputs against the board rules */
`timescale 1ns/1ps

module capitol_io_tb;

	logic                         clk_22;
	logic                         rst_n;
	capitol_ctrl_pkg::key_event_t key_ev;
	capitol_ctrl_pkg::joy_t       joy_0;
	capitol_ctrl_pkg::joy_t       joy_1;
	logic                         rotate;
	logic                         menu_reset;
	logic                         button_reset;
	capitol_av_pkg::scan_level_t  scan;
	capitol_av_pkg::rgb2_t        pix;
	logic                         hblank_bg;
	logic                         hblank_fg;
	logic                         vblank;
	logic                         hsync;
	logic                         vsync;
	capitol_av_pkg::audio_t       audio;
	capitol_ctrl_pkg::game_ctrl_t game_ctrl;
	logic                         game_reset;
	capitol_av_pkg::rgb6_t        pix_out;
	logic                         hs_n;
	logic                         vs_n;
	logic                         audio_l;
	logic                         audio_r;

	integer     seed = 3873;
	int         errors = 0;
	int         checks = 0;
	int         tests_failed = 0;
	logic [8:0] ks; // Expected up down left right coin start1 start2 fire barrier

	capitol_io_top capitol_io_top_inst (.*);

	initial begin
		clk_22 = 1'b0;
		forever #5 clk_22 = ~clk_22;
	end

	//----------------------------------------------------------------------
	// Checks and reference rules
	//----------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	// Polls for an active-low sync output
	task automatic wait_sync_active(input logic vertical);
		int n;
		n = 0;
		while ((vertical ? vs_n : hs_n) !== 1'b0 && n < 20) begin
			@(negedge clk_22);
			n++;
		end
		if ((vertical ? vs_n : hs_n) !== 1'b0) begin
			$display("Timed out waiting for %s to go low", vertical ? "vs_n" : "hs_n");
			errors++;
		end
	endtask

	function automatic capitol_ctrl_pkg::key_code_t key_code_at(input int i);
		case (i) // Same order as ks
			0: return capitol_ctrl_pkg::KEY_UP;
			1: return capitol_ctrl_pkg::KEY_DOWN;
			2: return capitol_ctrl_pkg::KEY_LEFT;
			3: return capitol_ctrl_pkg::KEY_RIGHT;
			4: return capitol_ctrl_pkg::KEY_COIN;
			5: return capitol_ctrl_pkg::KEY_START1;
			6: return capitol_ctrl_pkg::KEY_START2;
			7: return capitol_ctrl_pkg::KEY_FIRE;
			default: return capitol_ctrl_pkg::KEY_BARRIER;
		endcase
	endfunction

	// Fields coin start2 start1 left right barrier fire from the MSB down
	function automatic logic [6:0] expect_ctrl(input logic [7:0] j0, input logic [7:0] j1,
		input logic rot);
		logic [7:0] joy;
		logic left;
		logic right;
		joy   = j0 | j1;
		left  = rot ? (ks[2] | joy[1]) : (ks[1] | joy[2]);
		right = rot ? (ks[3] | joy[0]) : (ks[0] | joy[3]);
		return {ks[4], ks[6], ks[5], left, right, ks[8] | joy[5], ks[7] | joy[4]};
	endfunction

	function automatic logic [17:0] widen(input logic [5:0] p);
		return {{3{p[5:4]}}, {3{p[3:2]}}, {3{p[1:0]}}};
	endfunction

	function automatic logic [5:0] odd_white(input int lvl);
		case (lvl) // White on an odd line
			1: return 6'h30;
			2: return 6'h1F;
			3: return 6'h0F;
			default: return 6'h3F;
		endcase
	endfunction

	// Sends one key event and checks game_ctrl two cycles later
	// A negative idx leaves the expected panel alone
	task automatic send_key(input logic strobe, input logic pressed,
		input capitol_ctrl_pkg::key_code_t code, input int idx);
		key_ev = {strobe, pressed, code};
		@(negedge clk_22);
		key_ev.strobe = 1'b0;
		@(negedge clk_22);
		if (strobe && idx >= 0)
			ks[idx] = pressed;
		check_value("game_ctrl", 32'(game_ctrl), 32'(expect_ctrl(joy_0, joy_1, rotate)));
	endtask

	task automatic hold_reset();
		rst_n = 1'b0;
		repeat (16) @(negedge clk_22);
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		int   mark;
		int   ones;
		int   mismatches;
		logic blank;
		rst_n  = 1'b0;
		key_ev = '0;
		joy_0  = '0;
		joy_1  = '0;
		pix    = '0;
		audio  = '0;
		scan   = capitol_av_pkg::SCAN_OFF;
		ks     = '0;
		{rotate, menu_reset, button_reset, hblank_bg, hblank_fg, vblank, hsync, vsync} = '0;

		mark = errors;
		hold_reset();
		check_value("game_ctrl", 32'(game_ctrl), 32'h0);
		check_value("game_reset", 32'(game_reset), 32'h1); // Still in reset
		check_value("hs_n", 32'(hs_n), 32'h1);
		check_value("vs_n", 32'(vs_n), 32'h1);
		check_value("pix_out", 32'(pix_out), 32'h0);
		check_value("audio_l", 32'(audio_l), 32'h0);
		rst_n = 1'b1;
		for (int i = 0; i < 4; i++) begin
			{button_reset, menu_reset} = 2'(i);
			@(negedge clk_22);
			check_value("game_reset", 32'(game_reset), 32'(menu_reset | button_reset));
		end
		end_test("reset", mark);

		mark = errors;
		rotate = 1'b0; // Up and down only reach game_ctrl unrotated
		for (int i = 0; i < 2; i++) begin
			send_key(1'b1, 1'b1, key_code_at(i), i);
			send_key(1'b1, 1'b0, key_code_at(i), i);
		end
		rotate = 1'b1;
		for (int i = 0; i < 9; i++) begin
			send_key(1'b1, 1'b1, key_code_at(i), i);
			send_key(1'b1, 1'b0, key_code_at(i), i);
		end
		send_key(1'b1, 1'b1, capitol_ctrl_pkg::KEY_FIRE, 7);
		send_key(1'b1, 1'b1, 8'h1C, -1);                     // Not a panel key
		send_key(1'b0, 1'b0, capitol_ctrl_pkg::KEY_FIRE, 7); // Release without strobe
		send_key(1'b1, 1'b0, capitol_ctrl_pkg::KEY_FIRE, 7);
		end_test("key events", mark);

		mark = errors;
		for (int i = 0; i < 40; i++) begin
			joy_0  = 8'($random(seed));
			joy_1  = 8'($random(seed));
			rotate = 1'($random(seed));
			@(negedge clk_22);
			check_value("game_ctrl", 32'(game_ctrl), 32'(expect_ctrl(joy_0, joy_1, rotate)));
		end
		end_test("joystick", mark);

		mark = errors;
		for (int i = 0; i < 60; i++) begin
			pix = 6'($random(seed));
			{vblank, hblank_bg, hblank_fg, hsync, vsync} = 5'($random(seed));
			@(negedge clk_22);
			blank = vblank | (hblank_bg & hblank_fg);
			check_value("pix_out", 32'(pix_out), blank ? 32'h0 : 32'(widen(pix)));
			check_value("hs_n", 32'(hs_n), 32'(!hsync));
			check_value("vs_n", 32'(vs_n), 32'(!vsync));
		end
		end_test("video gate", mark);

		mark = errors;
		{vblank, hblank_bg, hblank_fg, hsync, vsync} = '0;
		pix = 6'h3F;
		@(negedge clk_22);
		for (int lvl = 0; lvl < 4; lvl++) begin
			scan  = capitol_av_pkg::scan_level_t'(2'(lvl));
			vsync = 1'b1; // New frame starts on an even line
			wait_sync_active(1'b1);
			vsync = 1'b0;
			@(negedge clk_22);
			check_value("pix_out even", 32'(pix_out), 32'h3FFFF);
			hsync = 1'b1;
			wait_sync_active(1'b0);
			@(negedge clk_22);
			check_value("pix_out odd", 32'(pix_out), 32'({3{odd_white(lvl)}}));
			hsync = 1'b0;
			@(negedge clk_22);
		end
		end_test("scanlines", mark);

		mark = errors;
		for (int t = 0; t < 3; t++) begin
			audio = 12'($random(seed));
			hold_reset();
			rst_n      = 1'b1;
			ones       = 0;
			mismatches = 0;
			for (int c = 0; c < 32768; c++) begin
				@(negedge clk_22);
				if (audio_l)
					ones++;
				if (audio_r !== audio_l)
					mismatches++;
			end
			check_value("audio_l ones", 32'(ones), 32'(audio) * 32'd8);
			check_value("audio_r mismatches", 32'(mismatches), 32'h0);
		end
		end_test("audio density", mark);

		$display("tests run 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: capitol_io.f
source/capitol_ctrl_pkg.sv
source/capitol_av_pkg.sv
source/key_latch.sv
source/control_mapper.sv
source/video_gate.sv
source/sigma_delta_dac.sv
source/capitol_io_top.sv
bench/capitol_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the Capitol I/O testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f capitol_io.f --top-module capitol_io_tb -o capitol_io_sim \
	&& ./obj_dir/capitol_io_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "testbench reported failure"; exit 1; }
echo "testbench run finished without failure"
exit 0
